//--- source/eeprom_settings.svh
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// system clocks per scl period
// multiple of 4, and 8 or more so a command can be taken between bits
`define EE_SCL_DIV 8

`define EE_ADDR_W 11        // 2 KB array, 8 blocks of 256

// 24Cxx family code in the top nibble of the control byte
`define EE_DEV_CODE 4'b1010

`endif

//--- source/eeprom_bus_pkg.sv
`default_nettype none

`include "eeprom_settings.svh"

package eeprom_bus_pkg;

    // block bits are the address bits above the low byte
    localparam int BLOCK_W = `EE_ADDR_W - 8;

    typedef enum logic
    {
        rw_write = 1'b0,
        rw_read  = 1'b1
    } rw_t;

    typedef struct packed
    {
        logic [3:0]         dev_code;
        logic [BLOCK_W-1:0] block;
        rw_t                rw;     // lsb, last on the wire
    } ctrl_fields_t;

    // same byte seen as wire bits or as decoded fields
    typedef union packed
    {
        logic [7:0]   raw;
        ctrl_fields_t fields;
    } ctrl_byte_t;

endpackage

`default_nettype wire

//--- source/eeprom_ctrl_pkg.sv
`default_nettype none

package eeprom_ctrl_pkg;

    typedef enum logic [1:0]
    {
        cmd_start      = 2'd0,
        cmd_stop       = 2'd1,
        cmd_write_byte = 2'd2,
        cmd_read_byte  = 2'd3
    } bit_cmd_t;

    typedef enum logic [3:0]
    {
        st_idle,
        st_ready,
        st_write_start,
        st_ctrl_write,
        st_addr_write,
        st_data_write,
        st_read_start,
        st_ctrl_read,
        st_data_read,
        st_stop,
        st_ackn
    } master_state_t;

endpackage

`default_nettype wire

//--- source/serial_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module serial_clock_gen
(
    input  wire  CLK,
    input  wire  RESET,
    input  wire  scl_en,
    output logic scl,
    output logic tick_low_mid,
    output logic tick_rise,
    output logic tick_high_mid
);

    localparam int DIV   = `EE_SCL_DIV;
    localparam int CNT_W = $clog2(DIV);

    localparam logic [CNT_W-1:0] QTR     = CNT_W'(DIV / 4);
    localparam logic [CNT_W-1:0] HALF    = CNT_W'(DIV / 2);
    localparam logic [CNT_W-1:0] THREE_Q = CNT_W'(3 * DIV / 4);
    localparam logic [CNT_W-1:0] LAST    = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] cnt;

    // outputs trail cnt by one cycle, so scl and strobes stay aligned
    always_ff @(posedge CLK)
    begin
        if (RESET || !scl_en)
        begin
            cnt           <= '0;
            scl           <= 1'b1;     // bus idles with scl high
            tick_low_mid  <= 1'b0;
            tick_rise     <= 1'b0;
            tick_high_mid <= 1'b0;
        end
        else
        begin
            cnt           <= (cnt == LAST) ? '0 : cnt + 1'b1;
            scl           <= (cnt >= HALF);
            tick_low_mid  <= (cnt == QTR);
            tick_rise     <= (cnt == HALF);
            tick_high_mid <= (cnt == THREE_Q);
        end
    end

endmodule

`default_nettype wire

//--- source/bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module bit_engine
(
    input  wire                       CLK,
    input  wire                       RESET,
    input  wire                       cmd_valid,
    input  wire eeprom_ctrl_pkg::bit_cmd_t cmd,
    input  wire  [7:0]                tx_byte,
    input  wire                       scl,
    input  wire                       tick_low_mid,
    input  wire                       tick_rise,
    input  wire                       tick_high_mid,
    input  wire                       sda_in,
    output logic                      cmd_done,
    output logic [7:0]                rx_byte,
    output logic                      ack_seen,
    output logic                      sda_drive_low,
    output logic                      scl_en
);

    import eeprom_ctrl_pkg::*;

    logic       active;
    bit_cmd_t   cur_cmd;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic       rise_seen;
    logic       high_act;
    logic       last_bit;
    logic       is_cond;
    logic       finish;
    logic       shift_en;

    assign high_act = active & tick_high_mid & rise_seen;   // only a full bit counts
    assign last_bit = bit_cnt[3];                            // ninth bit, ack slot
    assign is_cond  = (cur_cmd == cmd_start) || (cur_cmd == cmd_stop);
    assign finish   = high_act & (is_cond | last_bit);
    assign shift_en = high_act & ~is_cond & ~last_bit;
    assign rx_byte  = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active        <= 1'b0;
            cur_cmd       <= cmd_start;
            bit_cnt       <= '0;
            rise_seen     <= 1'b0;
            cmd_done      <= 1'b0;
            ack_seen      <= 1'b0;
            sda_drive_low <= 1'b0;
            scl_en        <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    active    <= 1'b1;
                    cur_cmd   <= cmd;
                    bit_cnt   <= '0;
                    rise_seen <= 1'b0;
                    scl_en    <= 1'b1;     // clock runs until the stop is done
                end
            end
            else if (tick_low_mid)
            begin
                case (cur_cmd)
                    cmd_start:      sda_drive_low <= 1'b0;   // high before scl rises
                    cmd_stop:       sda_drive_low <= 1'b1;
                    cmd_write_byte: sda_drive_low <= ~last_bit & ~shreg[7];
                    default:        sda_drive_low <= 1'b0;   // slave owns the line
                endcase
            end
            else if (tick_rise)
            begin
                rise_seen <= 1'b1;
            end
            else if (high_act)
            begin
                rise_seen <= 1'b0;
                if (cur_cmd == cmd_start)
                    sda_drive_low <= 1'b1;         // falling sda with scl high
                else if (cur_cmd == cmd_stop)
                    sda_drive_low <= 1'b0;         // rising sda with scl high
                else if (!last_bit)
                    bit_cnt <= bit_cnt + 1'b1;
                else if (cur_cmd == cmd_write_byte)
                    ack_seen <= ~sda_in;           // slave pulls low to ack

                if (finish)
                begin
                    active   <= 1'b0;
                    cmd_done <= 1'b1;
                    if (cur_cmd == cmd_stop)
                        scl_en <= 1'b0;
                end
            end
        end
    end

    // write shifts its msb out, read shifts the line in, same register
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
            shreg <= tx_byte;
        else if (shift_en)
            shreg <= {shreg[6:0], sda_in};
    end

    // data moves only mid scl low, start and stop move it mid scl high
    sda_change_ok: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_drive_low) |->
            $past(tick_low_mid && !scl) || $past(high_act && is_cond && scl));

    done_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done |=> !cmd_done);

endmodule

`default_nettype wire

//--- source/eeprom_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_master
(
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         wr,
    input  wire                         rd,
    input  wire  [`EE_ADDR_W-1:0]       addr,
    input  wire  [7:0]                  data_in,
    input  wire                         cmd_done,
    input  wire  [7:0]                  rx_byte,
    input  wire                         ack_seen,
    output logic                        cmd_valid,
    output eeprom_ctrl_pkg::bit_cmd_t   cmd,
    output logic [7:0]                  tx_byte,
    output logic [7:0]                  data_out,
    output logic                        done,
    output logic                        nack,
    output logic                        busy
);

    import eeprom_bus_pkg::*;
    import eeprom_ctrl_pkg::*;

    master_state_t        state;
    master_state_t        next_state;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [7:0]           data_q;
    logic                 is_read;
    logic                 pending;
    logic                 accept;
    logic                 issue;
    bit_cmd_t             issue_cmd;
    logic [7:0]           issue_byte;
    logic                 nack_hit;
    ctrl_byte_t           ctrl_wr;
    ctrl_byte_t           ctrl_rd;

    assign accept = (state == st_idle) && (wr || rd);

    always_comb
    begin
        ctrl_wr.fields.dev_code = `EE_DEV_CODE;
        ctrl_wr.fields.block    = addr_q[`EE_ADDR_W-1:8];
        ctrl_wr.fields.rw       = rw_write;
        ctrl_rd                 = ctrl_wr;
        ctrl_rd.fields.rw       = rw_read;
    end

    // next command goes out on the edge that leaves the current state
    always_comb
    begin
        next_state = state;
        issue      = 1'b0;
        issue_cmd  = cmd_start;
        issue_byte = addr_q[7:0];
        nack_hit   = 1'b0;
        case (state)
            st_idle:
                if (accept)
                    next_state = st_ready;
            st_ready:
            begin
                issue      = 1'b1;
                next_state = st_write_start;
            end
            st_write_start:
                if (cmd_done)
                begin
                    issue      = 1'b1;
                    issue_cmd  = cmd_write_byte;
                    issue_byte = ctrl_wr.raw;
                    next_state = st_ctrl_write;
                end
            st_ctrl_write:
                if (cmd_done)
                begin
                    issue      = 1'b1;
                    issue_cmd  = cmd_write_byte;   // address low byte
                    next_state = st_addr_write;
                end
            st_addr_write:
                if (cmd_done)
                begin
                    issue = 1'b1;
                    if (is_read)
                    begin
                        next_state = st_read_start;   // repeated start
                    end
                    else
                    begin
                        issue_cmd  = cmd_write_byte;
                        issue_byte = data_q;
                        next_state = st_data_write;
                    end
                end
            st_read_start:
                if (cmd_done)
                begin
                    issue      = 1'b1;
                    issue_cmd  = cmd_write_byte;
                    issue_byte = ctrl_rd.raw;
                    next_state = st_ctrl_read;
                end
            st_ctrl_read:
                if (cmd_done)
                begin
                    issue      = 1'b1;
                    issue_cmd  = cmd_read_byte;
                    next_state = st_data_read;
                end
            st_data_write, st_data_read:
                if (cmd_done)
                begin
                    issue      = 1'b1;
                    issue_cmd  = cmd_stop;
                    next_state = st_stop;
                end
            st_stop:
                if (cmd_done)
                    next_state = st_ackn;
            default:
                next_state = st_idle;   // st_ackn
        endcase

        // missing ack on a sent byte skips straight to the stop
        if (cmd_done && !ack_seen &&
            (state inside {st_ctrl_write, st_addr_write, st_data_write, st_ctrl_read}))
        begin
            nack_hit   = 1'b1;
            issue      = 1'b1;
            issue_cmd  = cmd_stop;
            next_state = st_stop;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= st_idle;
            cmd_valid <= 1'b0;
            cmd       <= cmd_start;
            done      <= 1'b0;
            nack      <= 1'b0;
            busy      <= 1'b0;
            is_read   <= 1'b0;
            pending   <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            cmd_valid <= issue;
            done      <= (next_state == st_ackn);
            busy      <= (next_state != st_idle);
            if (issue)
                cmd <= issue_cmd;
            if (accept)
            begin
                is_read <= rd & ~wr;   // write wins a tie
                nack    <= 1'b0;
            end
            else if (nack_hit)
                nack <= 1'b1;
            if (cmd_valid)
                pending <= 1'b1;
            else if (cmd_done)
                pending <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q <= addr;
            data_q <= data_in;
        end
        if (issue)
            tx_byte <= issue_byte;
        if (state == st_data_read && cmd_done)
            data_out <= rx_byte;
    end

    // engine must report done before the next command goes out
    no_overlap: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !pending);

endmodule

`default_nettype wire

//--- source/eeprom_wr.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_wr
(
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   wr,
    input  wire                   rd,
    input  wire  [`EE_ADDR_W-1:0] addr,
    input  wire  [7:0]            data_in,
    output logic [7:0]            data_out,
    output logic                  done,
    output logic                  nack,
    output logic                  busy,
    output logic                  scl,
    inout  wire                   sda
);

    import eeprom_ctrl_pkg::*;

    logic       cmd_valid;
    bit_cmd_t   cmd;
    logic [7:0] tx_byte;
    logic       cmd_done;
    logic [7:0] rx_byte;
    logic       ack_seen;
    logic       sda_drive_low;
    logic       sda_in;
    logic       scl_en;
    logic       tick_low_mid;
    logic       tick_rise;
    logic       tick_high_mid;

    // open drain, pull-up sits outside
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_master master
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .data_in  (data_in),
        .cmd_done (cmd_done),
        .rx_byte  (rx_byte),
        .ack_seen (ack_seen),
        .cmd_valid(cmd_valid),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .data_out (data_out),
        .done     (done),
        .nack     (nack),
        .busy     (busy)
    );

    bit_engine engine
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .tx_byte      (tx_byte),
        .scl          (scl),
        .tick_low_mid (tick_low_mid),
        .tick_rise    (tick_rise),
        .tick_high_mid(tick_high_mid),
        .sda_in       (sda_in),
        .cmd_done     (cmd_done),
        .rx_byte      (rx_byte),
        .ack_seen     (ack_seen),
        .sda_drive_low(sda_drive_low),
        .scl_en       (scl_en)
    );

    serial_clock_gen clk_gen
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl_en       (scl_en),
        .scl          (scl),
        .tick_low_mid (tick_low_mid),
        .tick_rise    (tick_rise),
        .tick_high_mid(tick_high_mid)
    );

endmodule

`default_nettype wire

//--- sim/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_model
(
    input  wire scl,
    inout  wire sda,
    input  wire present
);

    import eeprom_bus_pkg::*;

    typedef enum logic [2:0]
    {
        ph_idle,
        ph_ctrl,
        ph_addr,
        ph_data_wr,
        ph_data_rd
    } phase_t;

    logic [7:0] mem [0:2047];
    logic       sda_low    = 1'b0;
    logic       sda_bit;
    logic       scl_q      = 1'b1;
    logic       sda_q      = 1'b1;
    phase_t     phase      = ph_idle;
    phase_t     next_phase = ph_idle;
    logic [3:0] bit_cnt    = 4'd0;
    logic [7:0] shreg      = 8'd0;
    logic [7:0] tx_reg     = 8'd0;
    logic [2:0] block      = 3'd0;
    logic [7:0] addr_lo    = 8'd0;
    logic       ack_en     = 1'b0;
    ctrl_byte_t cb;

    assign sda     = sda_low ? 1'b0 : 1'bz;
    assign sda_bit = (sda !== 1'b0);    // released line reads high

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'ha5;
    end

    // full byte received, decide the ack and what follows
    task automatic decode_byte();
        ack_en     = 1'b1;
        next_phase = ph_idle;
        case (phase)
            ph_ctrl:
            begin
                cb.raw = shreg;
                if (!present || cb.fields.dev_code != `EE_DEV_CODE)
                    ack_en = 1'b0;          // not addressed
                else
                begin
                    block = cb.fields.block;
                    if (cb.fields.rw == rw_read)
                    begin
                        tx_reg     = mem[{block, addr_lo}];
                        next_phase = ph_data_rd;
                    end
                    else
                        next_phase = ph_addr;
                end
            end
            ph_addr:
            begin
                addr_lo    = shreg;
                next_phase = ph_data_wr;
            end
            ph_data_wr:
                mem[{block, addr_lo}] = shreg;
            default:
                ack_en = 1'b0;              // master answers a read byte
        endcase
    endtask

    task automatic sample_edge();
        if (phase == ph_idle)
            return;
        if (bit_cnt == 4'd8)
        begin
            bit_cnt = 4'd0;                 // ninth clock closes the byte
            phase   = next_phase;
            return;
        end
        shreg   = {shreg[6:0], sda_bit};
        bit_cnt = bit_cnt + 4'd1;
        if (bit_cnt == 4'd8)
            decode_byte();
    endtask

    task automatic drive_edge();
        if (phase == ph_idle)
            sda_low = 1'b0;
        else if (bit_cnt == 4'd8)
            sda_low = ack_en;
        else if (phase == ph_data_rd)
        begin
            sda_low = ~tx_reg[7];
            tx_reg  = tx_reg << 1;
        end
        else
            sda_low = 1'b0;
    endtask

    always @(posedge scl or negedge scl or posedge sda_bit or negedge sda_bit)
    begin
        if (scl && !scl_q)
            sample_edge();
        else if (!scl && scl_q)
            drive_edge();
        else if (scl && sda_q && !sda_bit)
        begin
            phase   = ph_ctrl;              // start or repeated start
            bit_cnt = 4'd0;
            sda_low = 1'b0;
        end
        else if (scl && !sda_q && sda_bit)
        begin
            phase   = ph_idle;              // stop
            sda_low = 1'b0;
        end
        scl_q = scl;
        sda_q = sda_bit;
    end

endmodule

`default_nettype wire

//--- sim/eeprom_wr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_settings.svh"

module eeprom_wr_tb;

    typedef enum {op_write, op_read, op_both, op_tie, op_busy} op_t;

    typedef struct
    {
        string                 name;
        op_t                   op;
        logic [`EE_ADDR_W-1:0] addr;
        logic [7:0]            data;
        logic                  present;
        logic [7:0]            exp_data;
        logic                  exp_nack;
    } row_t;

    localparam int N_FIXED        = 14;
    localparam int N_RAND         = 8;
    localparam int N_ROWS         = N_FIXED + N_RAND;
    localparam int TIMEOUT_CYCLES = N_ROWS * 45 * `EE_SCL_DIV * 2;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic                  present;
    logic [`EE_ADDR_W-1:0] addr;
    logic [7:0]            data_in;
    logic [7:0]            data_out;
    logic                  done;
    logic                  nack;
    logic                  busy;
    logic                  scl;
    wire                   sda;

    row_t       rows [N_ROWS];
    int         row_count = 0;
    int         cycles    = 0;
    logic [7:0] ref_mem   [0:2047];
    bit         ref_valid [0:2047];

    pullup (sda);

    eeprom_wr uut
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .data_in (data_in),
        .data_out(data_out),
        .done    (done),
        .nack    (nack),
        .busy    (busy),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model model
    (
        .scl    (scl),
        .sda    (sda),
        .present(present)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            stop_with_failure("timeout, the DUT never finished its transactions");
    end

    function automatic void add_row(input string name, input op_t op,
                                    input logic [`EE_ADDR_W-1:0] a, input logic [7:0] d,
                                    input logic p, input logic [7:0] exp_d,
                                    input logic exp_n);
        if (row_count < N_ROWS)
            rows[row_count] = '{name, op, a, d, p, exp_d, exp_n};
        row_count++;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp)
        else
            stop_with_failure($sformatf("error: %s %s expected %h got %h",
                                        name, what, exp, got));
    endtask

    // busy is high, so this request must be ignored
    task automatic poke_while_busy(input row_t r);
        repeat (20)
        begin
            @(negedge CLK);
            addr    = r.addr ^ 11'h400;
            data_in = ~r.data;
            wr      = 1'b1;
            assert (busy)
            else
                stop_with_failure("busy dropped in the middle of a write");
        end
        @(negedge CLK);
        wr = 1'b0;
    endtask

    task automatic transact(input row_t r, input logic do_wr, input logic do_rd);
        @(negedge CLK);
        present = r.present;
        addr    = r.addr;
        data_in = r.data;
        wr      = do_wr;
        rd      = do_rd;
        while (!busy)
            @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        if (r.op == op_busy)
            poke_while_busy(r);
        while (!done)
            @(negedge CLK);
        check_value(r.name, "nack", 8'(r.exp_nack), 8'(nack));
    endtask

    task automatic compare_read_data(input row_t r);
        if (!r.exp_nack)
        begin
            check_value(r.name, "data_out", r.exp_data, data_out);
            if (ref_valid[r.addr])
                check_value(r.name, "reference", ref_mem[r.addr], data_out);
        end
    endtask

    initial
    begin
        logic [7:0] d;

        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        present = 1'b1;
        addr    = '0;
        data_in = 8'd0;
        void'($urandom(32'hb181_8242));

        add_row("blk0_both",    op_both,  11'h012, 8'h5a, 1'b1, 8'h5a, 1'b0);
        add_row("blk5_both",    op_both,  11'h512, 8'hc3, 1'b1, 8'hc3, 1'b0);
        add_row("blk0_kept",    op_read,  11'h012, 8'h00, 1'b1, 8'h5a, 1'b0);
        add_row("absent_write", op_write, 11'h012, 8'hff, 1'b0, 8'h00, 1'b1);
        add_row("absent_read",  op_read,  11'h012, 8'h00, 1'b0, 8'h00, 1'b1);
        add_row("absent_kept",  op_read,  11'h012, 8'h00, 1'b1, 8'h5a, 1'b0);
        add_row("top_both",     op_both,  11'h7ff, 8'h81, 1'b1, 8'h81, 1'b0);
        add_row("zero_both",    op_both,  11'h000, 8'h00, 1'b1, 8'h00, 1'b0);
        add_row("tie_write",    op_tie,   11'h234, 8'h3c, 1'b1, 8'h00, 1'b0);
        add_row("tie_kept",     op_read,  11'h234, 8'h00, 1'b1, 8'h3c, 1'b0);
        add_row("seed_write",   op_write, 11'h345, 8'h11, 1'b1, 8'h00, 1'b0);
        add_row("busy_write",   op_busy,  11'h745, 8'h66, 1'b1, 8'h00, 1'b0);
        add_row("busy_kept",    op_read,  11'h345, 8'h00, 1'b1, 8'h11, 1'b0);
        add_row("busy_read",    op_read,  11'h745, 8'h00, 1'b1, 8'h66, 1'b0);
        for (int i = 0; i < N_RAND; i++)
        begin
            d = 8'($urandom);
            add_row($sformatf("rand_%0d", i), op_both, 11'($urandom), d, 1'b1, d, 1'b0);
        end
        assert (row_count == N_ROWS)
        else
            stop_with_failure("stimulus table size does not match its row count");

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_value("after_reset", "busy", 8'd0, {7'd0, busy});
        check_value("after_reset", "done", 8'd0, {7'd0, done});
        check_value("after_reset", "nack", 8'd0, {7'd0, nack});
        check_value("after_reset", "scl", 8'd1, {7'd0, scl});
        check_value("after_reset", "sda", 8'd1, {7'd0, sda});

        for (int i = 0; i < N_ROWS; i++)
        begin
            if (rows[i].op != op_read)
            begin
                transact(rows[i], 1'b1, rows[i].op == op_tie);
                if (!rows[i].exp_nack)
                begin
                    ref_mem[rows[i].addr]   = rows[i].data;
                    ref_valid[rows[i].addr] = 1'b1;
                end
            end
            if (rows[i].op == op_read || rows[i].op == op_both)
            begin
                transact(rows[i], 1'b0, 1'b1);
                compare_read_data(rows[i]);
            end
        end

        repeat (4) @(negedge CLK);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/eeprom_bus_pkg.sv
source/eeprom_ctrl_pkg.sv
source/serial_clock_gen.sv
source/bit_engine.sv
source/eeprom_master.sv
source/eeprom_wr.sv
sim/eeprom_model.sv
sim/eeprom_wr_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= eeprom_wr_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
